// ==== logic/xc_pkg.sv ====
// ######################################
// all sizes are fixed here, modules take no parameters
// counts are 16 bit and do not saturate
// ######################################
`default_nettype none

package xc_pkg;

	// detector lines and derived count layout
	localparam int NUM_LINES = 4;
	localparam int NUM_PAIRS = NUM_LINES * (NUM_LINES - 1) / 2;
	localparam int NUM_COUNTS = NUM_LINES + NUM_PAIRS;

	// clock cycles between sampling strobes
	localparam int SAMPLE_DIV = 16;
	// strobes per integration window
	localparam int WINDOW_SAMPLES = 32;
	// clock cycles per uart bit
	localparam int BAUD_DIV = 8;

	// frame is header, then each count high byte first
	localparam logic [7:0] FRAME_HEADER = 8'hA5;
	localparam int FRAME_BYTES = 1 + 2 * NUM_COUNTS;

	// one sample of every line
	typedef logic [NUM_LINES-1:0] line_t;
	typedef logic [15:0] count_t;
	typedef logic [7:0] byte_t;

	// count index: lines 0..3 first, then pairs
	// pair order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)

	typedef enum logic [1:0] {FRM_IDLE, FRM_SEND_BYTE, FRM_WAIT_BYTE} frame_state_t;
	typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_t;

endpackage

`default_nettype wire

// ==== logic/xc_result_if.sv ====
// ######################################
// counts hold from one valid pulse to the next
// busy is the frame sender's level, no handshake
// ######################################
`timescale 1ns/10ps
`default_nettype none

interface xc_result_if
	import xc_pkg::*;
();

	// snapshot of one window, lines then pairs
	count_t counts [NUM_COUNTS];
	// one cycle, counts just updated
	logic valid;
	// frame in progress
	logic busy;

	modport source (
		output counts,
		output valid,
		input  busy
	);

	modport sink (
		input  counts,
		input  valid,
		output busy
	);

endinterface

`default_nettype wire

// ==== logic/xc_timing.sv ====
// ######################################
// strobe runs free from reset, enable only gates windows
// integrating is high in the first counted strobe cycle
// ######################################
`timescale 1ns/10ps
`default_nettype none

module xc_timing
	import xc_pkg::*;
(
	input  logic clki,
	input  logic rst_n,
	input  logic enable,
	input  logic busy,
	output logic sample_stb,
	output logic integrating,
	output logic window_end
);

	logic [$clog2(SAMPLE_DIV)-1:0] div_cnt;
	logic [$clog2(WINDOW_SAMPLES)-1:0] win_cnt;
	logic integ_q;
	logic win_start;
	logic counted;

	// strobe on the last cycle of each divider period
	assign sample_stb = (div_cnt == ($bits(div_cnt))'(SAMPLE_DIV - 1));

	// new window only on a strobe, idle and not sending
	assign win_start = sample_stb && enable && !busy && !integ_q;

	// combinational rise so the opening strobe is counted too
	assign integrating = integ_q || win_start;
	assign counted = sample_stb && integrating;

	always_ff @(posedge clki) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (sample_stb) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge clki) begin
		if (!rst_n) begin
			win_cnt <= '0;
			integ_q <= 1'b0;
			window_end <= 1'b0;
		end else begin
			window_end <= 1'b0;
			if (counted) begin
				if (win_cnt == ($bits(win_cnt))'(WINDOW_SAMPLES - 1)) begin
					// last strobe, drop out next cycle
					win_cnt <= '0;
					integ_q <= 1'b0;
					window_end <= 1'b1;
				end else begin
					win_cnt <= win_cnt + 1'b1;
					integ_q <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/xc_correlator.sv ====
// ######################################
// lag zero only, one sample per counted strobe
// a window of WINDOW_SAMPLES cannot overflow a count
// ######################################
`timescale 1ns/10ps
`default_nettype none

module xc_correlator
	import xc_pkg::*;
(
	input  logic clki,
	input  logic rst_n,
	input  line_t lines,
	input  logic sample_stb,
	input  logic integrating,
	input  logic window_end,
	xc_result_if.source res
);

	// running sums, same index layout as the snapshot
	count_t acc [NUM_COUNTS];
	logic [NUM_PAIRS-1:0] pair_hit;
	logic [NUM_COUNTS-1:0] hits;
	logic counted;

	assign counted = sample_stb && integrating;

	// coincidences in package pair order
	always_comb begin
		int p;
		p = 0;
		pair_hit = '0;
		for (int i = 0; i < NUM_LINES; i++) begin
			for (int j = i + 1; j < NUM_LINES; j++) begin
				pair_hit[p] = lines[i] && lines[j];
				p++;
			end
		end
	end

	// lines in the low bits, pairs above
	assign hits = {pair_hit, lines};

	// accumulators clear at window end
	always_ff @(posedge clki) begin
		if (!rst_n) begin
			for (int k = 0; k < NUM_COUNTS; k++) begin
				acc[k] <= '0;
			end
		end else if (window_end) begin
			for (int k = 0; k < NUM_COUNTS; k++) begin
				acc[k] <= '0;
			end
		end else if (counted) begin
			for (int k = 0; k < NUM_COUNTS; k++) begin
				acc[k] <= acc[k] + count_t'(hits[k]);
			end
		end
	end

	// snapshot, held until the next window closes
	always_ff @(posedge clki) begin
		if (window_end) begin
			for (int k = 0; k < NUM_COUNTS; k++) begin
				res.counts[k] <= acc[k];
			end
		end
	end

	// valid trails window_end by one cycle
	always_ff @(posedge clki) begin
		if (!rst_n) begin
			res.valid <= 1'b0;
		end else begin
			res.valid <= window_end;
		end
	end

endmodule

`default_nettype wire

// ==== logic/xc_frame_tx.sv ====
// ######################################
// gaps between bytes are allowed, busy marks the frame
// counts must stay put until busy falls
// ######################################
`timescale 1ns/10ps
`default_nettype none

module xc_frame_tx
	import xc_pkg::*;
(
	input  logic clki,
	input  logic rst_n,
	input  logic tx_busy,
	xc_result_if.sink res,
	output byte_t tx_byte,
	output logic tx_start
);

	frame_state_t state;
	logic [$clog2(FRAME_BYTES)-1:0] idx;
	logic [$clog2(FRAME_BYTES)-1:0] pos;
	logic [$clog2(FRAME_BYTES)-2:0] cnt_sel;
	count_t cnt_word;

	// byte 0 is the header, then two bytes per count
	assign pos = idx - 1'b1;
	assign cnt_sel = pos[$bits(pos)-1:1];
	assign cnt_word = res.counts[cnt_sel];

	// odd index carries the high byte
	always_comb begin
		if (idx == '0) begin
			tx_byte = FRAME_HEADER;
		end else if (idx[0]) begin
			tx_byte = cnt_word[15:8];
		end else begin
			tx_byte = cnt_word[7:0];
		end
	end

	// hand over as soon as the serializer is free
	assign tx_start = (state == FRM_SEND_BYTE) && !tx_busy;

	always_ff @(posedge clki) begin
		if (!rst_n) begin
			state <= FRM_IDLE;
			idx <= '0;
			res.busy <= 1'b0;
		end else begin
			case (state)
				FRM_IDLE: begin
					if (res.valid) begin
						idx <= '0;
						res.busy <= 1'b1;
						state <= FRM_SEND_BYTE;
					end
				end
				FRM_SEND_BYTE: begin
					if (tx_start) begin
						state <= FRM_WAIT_BYTE;
					end
				end
				FRM_WAIT_BYTE: begin
					// tx_busy is already up the cycle after tx_start
					if (!tx_busy) begin
						if (idx == ($bits(idx))'(FRAME_BYTES - 1)) begin
							res.busy <= 1'b0;
							state <= FRM_IDLE;
						end else begin
							idx <= idx + 1'b1;
							state <= FRM_SEND_BYTE;
						end
					end
				end
				default: state <= FRM_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/xc_uart_tx.sv ====
// ######################################
// 8N1, lsb first, BAUD_DIV clocks per bit
// tx_start is ignored while busy
// ######################################
`timescale 1ns/10ps
`default_nettype none

module xc_uart_tx
	import xc_pkg::*;
(
	input  logic clki,
	input  logic rst_n,
	input  byte_t tx_byte,
	input  logic tx_start,
	output logic tx,
	output logic tx_busy
);

	uart_state_t state;
	logic [$clog2(BAUD_DIV)-1:0] baud_cnt;
	logic [2:0] bit_cnt;
	byte_t shreg;
	logic bit_done;

	assign bit_done = (baud_cnt == ($bits(baud_cnt))'(BAUD_DIV - 1));
	assign tx_busy = (state != UART_IDLE);

	// line level straight from state and shifter
	always_comb begin
		case (state)
			UART_START: tx = 1'b0;
			UART_DATA: tx = shreg[0];
			default: tx = 1'b1;
		endcase
	end

	always_ff @(posedge clki) begin
		if (!rst_n) begin
			state <= UART_IDLE;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			if (state == UART_IDLE) begin
				baud_cnt <= '0;
			end else if (bit_done) begin
				baud_cnt <= '0;
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
			case (state)
				UART_IDLE: begin
					if (tx_start) begin
						state <= UART_START;
					end
				end
				UART_START: begin
					if (bit_done) begin
						bit_cnt <= '0;
						state <= UART_DATA;
					end
				end
				UART_DATA: begin
					if (bit_done) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= UART_STOP;
						end
					end
				end
				UART_STOP: begin
					if (bit_done) begin
						state <= UART_IDLE;
					end
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

	// payload shifter, lsb goes out first
	always_ff @(posedge clki) begin
		if (state == UART_IDLE && tx_start) begin
			shreg <= tx_byte;
		end else if (state == UART_DATA && bit_done) begin
			shreg <= {1'b0, shreg[7:1]};
		end
	end

endmodule

`default_nettype wire

// ==== logic/xc_top.sv ====
// ######################################
// sampling_clk is a one cycle strobe, not a clock
// lines are sampled as is, no synchronizer
// ######################################
`timescale 1ns/10ps
`default_nettype none

module xc_top
	import xc_pkg::*;
(
	input  logic clki,
	input  logic rst_n,
	input  logic enable,
	input  line_t lines,
	output logic tx,
	output logic sampling_clk,
	output logic integrating
);

	logic window_end;
	logic frame_busy;
	byte_t tx_byte;
	logic tx_start;
	logic tx_busy;

	xc_result_if res_if ();

	// window control sees the frame sender only through busy
	assign frame_busy = res_if.busy;

	xc_timing u_timing (
		.clki        (clki),
		.rst_n       (rst_n),
		.enable      (enable),
		.busy        (frame_busy),
		.sample_stb  (sampling_clk),
		.integrating (integrating),
		.window_end  (window_end)
	);

	xc_correlator u_correlator (
		.clki        (clki),
		.rst_n       (rst_n),
		.lines       (lines),
		.sample_stb  (sampling_clk),
		.integrating (integrating),
		.window_end  (window_end),
		.res         (res_if.source)
	);

	xc_frame_tx u_frame_tx (
		.clki     (clki),
		.rst_n    (rst_n),
		.tx_busy  (tx_busy),
		.res      (res_if.sink),
		.tx_byte  (tx_byte),
		.tx_start (tx_start)
	);

	xc_uart_tx u_uart_tx (
		.clki     (clki),
		.rst_n    (rst_n),
		.tx_byte  (tx_byte),
		.tx_start (tx_start),
		.tx       (tx),
		.tx_busy  (tx_busy)
	);

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
// ######################################
// 4 ns clock, reset low for 5 cycles
// reset released on a falling edge
// ######################################
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clki,
	output logic rst_n
);

	// half period of 2 ns
	initial begin
		clki = 1'b0;
		forever #2 clki = ~clki;
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clki);
		// release away from the active edge
		@(negedge clki);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== dv/tb_xc_top.sv ====
// ######################################
// inputs change on the falling edge and uart is sampled mid-bit
// expects back-pressure and one frame per closed window
// ######################################
`timescale 1ns/10ps
`default_nettype none

module tb_xc_top
	import xc_pkg::*;
();

	typedef enum int {LINES_LOW, LINES_RANDOM, LINES_HIGH} line_mode_t;

	// observation and timeout lengths in clock cycles
	localparam int QUIET_CYCLES = 2 * WINDOW_SAMPLES * SAMPLE_DIV;
	localparam int FRAME_WAIT = 4 * WINDOW_SAMPLES * SAMPLE_DIV;
	localparam int BYTE_GAP = 4 * BAUD_DIV;
	localparam int START_WAIT = 4 * SAMPLE_DIV;
	localparam int RESET_WAIT = 16;

	logic clki;
	logic rst_n;
	logic enable;
	line_t lines;
	logic tx;
	logic sampling_clk;
	logic integrating;

	// pair order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
	int pair_a [NUM_PAIRS] = '{0, 0, 0, 1, 1, 2};
	int pair_b [NUM_PAIRS] = '{1, 2, 3, 2, 3, 3};

	int seed;
	line_mode_t line_mode;
	line_t win_samples [$];
	byte_t exp_q [$];
	logic integ_prev;
	// set by the uart decoder for the whole frame
	logic rx_active;

	tb_clock u_clock (
		.clki  (clki),
		.rst_n (rst_n)
	);

	xc_top u_dut (
		.clki         (clki),
		.rst_n        (rst_n),
		.enable       (enable),
		.lines        (lines),
		.tx           (tx),
		.sampling_clk (sampling_clk),
		.integrating  (integrating)
	);

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	// count c covers lines 0..3 and then the pairs in table order
	function automatic count_t expected_count(input line_t smp [$], input int c);
		count_t cnt;
		cnt = '0;
		foreach (smp[n]) begin
			if (c < NUM_LINES) begin
				if (smp[n][c]) begin
					cnt = cnt + count_t'(1);
				end
			end else if (smp[n][pair_a[c - NUM_LINES]] && smp[n][pair_b[c - NUM_LINES]]) begin
				cnt = cnt + count_t'(1);
			end
		end
		return cnt;
	endfunction

	// expected frame of the window just closed
	task automatic close_window();
		count_t cnt;
		assert (win_samples.size() == WINDOW_SAMPLES) else
			stop_on_error($sformatf("mismatch samples in window: got %h expected %h",
				win_samples.size(), WINDOW_SAMPLES));
		exp_q.push_back(FRAME_HEADER);
		for (int c = 0; c < NUM_COUNTS; c++) begin
			cnt = expected_count(win_samples, c);
			// high byte first
			exp_q.push_back(cnt[15:8]);
			exp_q.push_back(cnt[7:0]);
		end
		win_samples.delete();
	endtask

	// one new line value per falling edge
	initial begin
		seed = 28483;
		lines = '0;
		forever begin
			@(negedge clki);
			case (line_mode)
				LINES_RANDOM: lines = line_t'($random(seed));
				LINES_HIGH: lines = '1;
				default: lines = '0;
			endcase
		end
	end

	// sample recorder and window close detection
	always @(posedge clki) begin
		if (rst_n) begin
			if (sampling_clk && integrating) begin
				win_samples.push_back(lines);
			end
			if (integ_prev && !integrating) begin
				close_window();
			end
			assert (!(integrating && rx_active)) else
				stop_on_error("integrating was high while a frame was being sent");
		end
		integ_prev = integrating;
	end

	task automatic wait_start_bit(input int limit);
		int n;
		n = 0;
		while (tx !== 1'b0) begin
			@(negedge clki);
			n++;
			assert (n <= limit) else
				stop_on_error("no start bit appeared on tx before the timeout");
		end
	endtask

	task automatic receive_byte(input int limit, output byte_t data);
		wait_start_bit(limit);
		// half a bit in, then one bit period per sample
		repeat (BAUD_DIV / 2) @(negedge clki);
		assert (tx === 1'b0) else
			stop_on_error("start bit on tx ended early");
		for (int b = 0; b < 8; b++) begin
			repeat (BAUD_DIV) @(negedge clki);
			data[b] = tx;
		end
		repeat (BAUD_DIV) @(negedge clki);
		assert (tx === 1'b1) else
			stop_on_error("stop bit on tx was missing");
	endtask

	task automatic receive_frame();
		byte_t got;
		byte_t want;
		wait_start_bit(FRAME_WAIT);
		assert (exp_q.size() == FRAME_BYTES) else
			stop_on_error("a frame started without exactly one closed window");
		rx_active = 1'b1;
		for (int k = 0; k < FRAME_BYTES; k++) begin
			receive_byte(BYTE_GAP, got);
			want = exp_q.pop_front();
			assert (got === want) else
				stop_on_error($sformatf("mismatch tx byte %0d: got %h expected %h",
					k, got, want));
		end
		rx_active = 1'b0;
	endtask

	task automatic wait_integrating(input int limit);
		int n;
		n = 0;
		while (integrating !== 1'b1) begin
			@(negedge clki);
			n++;
			assert (n <= limit) else
				stop_on_error("integrating did not rise after enable went high");
		end
	endtask

	// opens one window and drops enable once integrating is latched
	task automatic run_window();
		@(negedge clki);
		enable = 1'b1;
		wait_integrating(START_WAIT);
		@(negedge clki);
		enable = 1'b0;
	endtask

	// tx idle and no window while strobes keep running
	task automatic check_quiet(input int cycles);
		int strobes;
		strobes = 0;
		repeat (cycles) begin
			@(negedge clki);
			assert (tx === 1'b1) else
				stop_on_error($sformatf("mismatch tx: got %h expected 1", tx));
			assert (integrating === 1'b0) else
				stop_on_error($sformatf("mismatch integrating: got %h expected 0", integrating));
			if (sampling_clk) begin
				strobes++;
			end
		end
		assert (strobes == cycles / SAMPLE_DIV) else
			stop_on_error($sformatf("mismatch sampling_clk pulses: got %h expected %h",
				strobes, cycles / SAMPLE_DIV));
	endtask

	initial begin
		int n;
		enable = 1'b0;
		line_mode = LINES_LOW;
		rx_active = 1'b0;
		n = 0;
		while (rst_n !== 1'b1) begin
			@(negedge clki);
			n++;
			assert (n <= RESET_WAIT) else
				stop_on_error("reset was never released");
		end
		// idle after reset
		check_quiet(QUIET_CYCLES);
		// all low, then random, then all high
		run_window();
		receive_frame();
		line_mode = LINES_RANDOM;
		run_window();
		receive_frame();
		line_mode = LINES_HIGH;
		run_window();
		receive_frame();
		// three back to back windows
		line_mode = LINES_RANDOM;
		@(negedge clki);
		enable = 1'b1;
		receive_frame();
		receive_frame();
		wait_integrating(START_WAIT);
		@(negedge clki);
		enable = 1'b0;
		receive_frame();
		// line stays idle with enable low
		check_quiet(QUIET_CYCLES);
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/xc_pkg.sv
logic/xc_result_if.sv
logic/xc_timing.sv
logic/xc_correlator.sv
logic/xc_frame_tx.sv
logic/xc_uart_tx.sv
logic/xc_top.sv
dv/tb_clock.sv
dv/tb_xc_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the correlator testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_xc_top -f verilog.f -o tb_xc_top
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

./obj_dir/tb_xc_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
